/* rtl/gat_defines.svh */
// GAT front end sizes
`ifndef GAT_DEFINES_SVH
`define GAT_DEFINES_SVH

// ============================================================
// Base sizes
// ============================================================
`define GAT_DATA_WIDTH          8
`define GAT_TOTAL_NODES         8
`define GAT_NUM_FEATURE_IN      16
`define GAT_NUM_FEATURE_OUT     4
`define GAT_H_NUM_SPARSE_DATA   64
`define GAT_NUM_WEIGHT_BANKS    2
`define GAT_FEAT_WIDTH          32

// ============================================================
// Derived depths and widths
// ============================================================
`define GAT_COL_IDX_W     ($clog2(`GAT_NUM_FEATURE_IN))
`define GAT_ROW_LEN_W     ($clog2(`GAT_NUM_FEATURE_IN + 1))
`define GAT_OUT_COL_W     ($clog2(`GAT_NUM_FEATURE_OUT))
`define GAT_H_ADDR_W      ($clog2(`GAT_H_NUM_SPARSE_DATA))
`define GAT_NODE_ADDR_W   ($clog2(`GAT_TOTAL_NODES))
`define GAT_WGT_DEPTH     (`GAT_NUM_WEIGHT_BANKS * `GAT_NUM_FEATURE_IN * `GAT_NUM_FEATURE_OUT)
`define GAT_WGT_ADDR_W    ($clog2(`GAT_WGT_DEPTH))
`define GAT_FEAT_DEPTH    (`GAT_TOTAL_NODES * `GAT_NUM_FEATURE_OUT)
`define GAT_FEAT_ADDR_W   ($clog2(`GAT_FEAT_DEPTH))

`endif

/* rtl/gat_mem_pkg.sv */
// GAT memory formats
`default_nettype none

`include "gat_defines.svh"

package gat_mem_pkg;

  // ============================================================
  // Memory entries
  // ============================================================

  // One nonzero of H
  typedef struct packed {
    logic signed [`GAT_DATA_WIDTH-1:0] val;
    logic [`GAT_COL_IDX_W-1:0]         col;
  } h_entry_t;

  // Nonzero count of one row, 0 up to the full row
  typedef struct packed {
    logic [`GAT_ROW_LEN_W-1:0] row_len;
  } node_info_t;

  // ============================================================
  // Write ports
  // ============================================================

  typedef struct packed {
    logic                     ena;
    logic                     wea;
    logic [`GAT_H_ADDR_W-1:0] addr;
    h_entry_t                 din;
  } h_data_wr_t;

  typedef struct packed {
    logic                        ena;
    logic                        wea;
    logic [`GAT_NODE_ADDR_W-1:0] addr;
    node_info_t                  din;
  } node_info_wr_t;

  // Address is bank, row, column from msb to lsb
  typedef struct packed {
    logic                       ena;
    logic                       wea;
    logic [`GAT_WGT_ADDR_W-1:0] addr;
    logic [`GAT_DATA_WIDTH-1:0] din;
  } wgt_wr_t;

  // Engine side, always a write
  typedef struct packed {
    logic                        ena;
    logic [`GAT_FEAT_ADDR_W-1:0] addr;
    logic [`GAT_FEAT_WIDTH-1:0]  din;
  } feat_wr_t;

endpackage

`default_nettype wire

/* rtl/gat_core_pkg.sv */
// GAT engine types
`default_nettype none

`include "gat_defines.svh"

package gat_core_pkg;

  // Sequencer states
  typedef enum logic [2:0] {
    idle,
    row_fetch,
    entry_fetch,
    mac,
    write_back,
    done
  } xform_state_t;

  // One output feature
  typedef logic [`GAT_FEAT_WIDTH-1:0] feat_t;

  // Running sums of one output row
  typedef feat_t [`GAT_NUM_FEATURE_OUT-1:0] acc_vec_t;

endpackage

`default_nettype wire

/* rtl/gat_bram.sv */
// Simple dual-port memory
`timescale 1ns/1ps
`default_nettype none

module gat_bram #(
  parameter type data_t   = logic [7:0],
  parameter int  DEPTH    = 64,
  localparam int ADDR_W   = $clog2(DEPTH)
) (
  input  logic              clk,

  // Write side
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  data_t             wr_data,

  // Read side, data one cycle after address
  input  logic [ADDR_W-1:0] rd_addr,
  output data_t             rd_data
);

  data_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // ============================================================
  // Checks
  // ============================================================

  a_wr_addr_range : assert property (
    @(posedge clk) wr_en |-> (int'(wr_addr) < DEPTH)
  ) else $error("gat_bram write address %0d beyond depth %0d", wr_addr, DEPTH);

endmodule

`default_nettype wire

/* rtl/gat_memory_controller.sv */
// GAT memory controller
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module gat_memory_controller
  import gat_mem_pkg::*;
(
  input  logic                         clk,

  // Host loading
  input  h_data_wr_t                   h_data_wr,
  input  node_info_wr_t                node_info_wr,
  input  wgt_wr_t                      wgt_wr,

  // Engine reads
  input  logic [`GAT_H_ADDR_W-1:0]     h_addrb,
  output h_entry_t                     h_dout,
  input  logic [`GAT_NODE_ADDR_W-1:0]  node_info_addrb,
  output node_info_t                   node_info_dout,
  input  logic [`GAT_WGT_ADDR_W-1:0]   wgt_addrb,
  output logic [`GAT_DATA_WIDTH-1:0]   wgt_dout,

  // Feature memory
  input  feat_wr_t                     feat_wr,
  input  logic [`GAT_FEAT_ADDR_W-1:0]  feat_addrb,
  output logic [`GAT_FEAT_WIDTH-1:0]   feat_dout
);

  logic h_we;
  logic node_info_we;
  logic wgt_we;

  assign h_we         = h_data_wr.ena & h_data_wr.wea;
  assign node_info_we = node_info_wr.ena & node_info_wr.wea;
  assign wgt_we       = wgt_wr.ena & wgt_wr.wea;

  // ============================================================
  // Memories
  // ============================================================

  gat_bram #(
    .data_t (h_entry_t),
    .DEPTH  (`GAT_H_NUM_SPARSE_DATA)
  ) u_h_data_bram (
    .clk     (clk),
    .wr_en   (h_we),
    .wr_addr (h_data_wr.addr),
    .wr_data (h_data_wr.din),
    .rd_addr (h_addrb),
    .rd_data (h_dout)
  );

  gat_bram #(
    .data_t (node_info_t),
    .DEPTH  (`GAT_TOTAL_NODES)
  ) u_node_info_bram (
    .clk     (clk),
    .wr_en   (node_info_we),
    .wr_addr (node_info_wr.addr),
    .wr_data (node_info_wr.din),
    .rd_addr (node_info_addrb),
    .rd_data (node_info_dout)
  );

  // Both layer banks share one array
  gat_bram #(
    .data_t (logic [`GAT_DATA_WIDTH-1:0]),
    .DEPTH  (`GAT_WGT_DEPTH)
  ) u_wgt_bram (
    .clk     (clk),
    .wr_en   (wgt_we),
    .wr_addr (wgt_wr.addr),
    .wr_data (wgt_wr.din),
    .rd_addr (wgt_addrb),
    .rd_data (wgt_dout)
  );

  gat_bram #(
    .data_t (logic [`GAT_FEAT_WIDTH-1:0]),
    .DEPTH  (`GAT_FEAT_DEPTH)
  ) u_feat_bram (
    .clk     (clk),
    .wr_en   (feat_wr.ena),
    .wr_addr (feat_wr.addr),
    .wr_data (feat_wr.din),
    .rd_addr (feat_addrb),
    .rd_data (feat_dout)
  );

  // Node pointer only moves while the engine walks a run
  a_no_load_in_run : assert property (
    @(posedge clk) (h_we || wgt_we) |-> $stable(node_info_addrb)
  ) else $error("host write to H or W memory during an engine run");

endmodule

`default_nettype wire

/* rtl/gat_transform.sv */
// Sparse feature transform engine
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module gat_transform
  import gat_mem_pkg::*, gat_core_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,

  // Host levels
  input  logic                         h_data_load_done,
  input  logic                         node_info_load_done,
  input  logic                         wgt_load_done,
  input  logic                         gat_layer,

  // Memory reads
  output logic [`GAT_NODE_ADDR_W-1:0]  node_info_addrb,
  output logic [`GAT_H_ADDR_W-1:0]     h_addrb,
  output logic [`GAT_WGT_ADDR_W-1:0]   wgt_addrb,
  input  node_info_t                   node_info_dout,
  input  h_entry_t                     h_dout,
  input  logic [`GAT_DATA_WIDTH-1:0]   wgt_dout,

  // Results
  output feat_wr_t                     feat_wr,
  output logic                         gat_ready
);

  localparam int FW        = `GAT_FEAT_WIDTH;
  localparam int DW        = `GAT_DATA_WIDTH;
  localparam int OCW       = `GAT_OUT_COL_W;
  localparam int NAW       = `GAT_NODE_ADDR_W;
  localparam int LAST_NODE = `GAT_TOTAL_NODES - 1;
  localparam int NUM_OUT   = `GAT_NUM_FEATURE_OUT;

  xform_state_t                 state;
  logic                         fetch_wait;
  logic [NAW-1:0]               node_idx;
  logic [`GAT_H_ADDR_W:0]       h_ptr;      // one extra bit to catch overrun
  logic [`GAT_ROW_LEN_W-1:0]    row_left;
  logic [OCW:0]                 col_cnt;
  logic                         bank_sel;

  logic signed [DW-1:0]         ent_val;
  logic [`GAT_COL_IDX_W-1:0]    ent_col;
  acc_vec_t                     acc;

  logic                         all_loaded;
  logic [OCW-1:0]               mac_col;
  logic signed [2*DW-1:0]       prod;

  assign all_loaded = h_data_load_done & node_info_load_done & wgt_load_done;

  // ============================================================
  // Read addresses
  // ============================================================
  assign node_info_addrb = node_idx;
  assign h_addrb         = h_ptr[`GAT_H_ADDR_W-1:0];
  // Bank, row from the entry's column, output column
  assign wgt_addrb       = {bank_sel, ent_col, col_cnt[OCW-1:0]};

  // Weight data lags its address by one, so it belongs to the previous column
  assign mac_col = col_cnt[OCW-1:0] - OCW'(1);
  assign prod    = ent_val * $signed(wgt_dout);

  always_comb begin
    feat_wr.ena  = (state == write_back);
    feat_wr.addr = {node_idx, col_cnt[OCW-1:0]};
    feat_wr.din  = acc[col_cnt[OCW-1:0]];
  end

  // ============================================================
  // Sequencer
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= idle;
      fetch_wait <= 1'b0;
      node_idx   <= '0;
      h_ptr      <= '0;
      row_left   <= '0;
      col_cnt    <= '0;
      bank_sel   <= 1'b0;
      gat_ready  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (all_loaded && !gat_ready) begin
            node_idx <= '0;
            h_ptr    <= '0;
            bank_sel <= gat_layer;
            state    <= row_fetch;
          end
        end

        // Wait one cycle for the row length
        row_fetch: begin
          fetch_wait <= ~fetch_wait;
          if (fetch_wait) begin
            row_left <= node_info_dout.row_len;
            col_cnt  <= '0;
            state    <= (node_info_dout.row_len == '0) ? write_back : entry_fetch;
          end
        end

        entry_fetch: begin
          fetch_wait <= ~fetch_wait;
          if (fetch_wait) begin
            h_ptr    <= h_ptr + 1'b1;
            row_left <= row_left - 1'b1;
            col_cnt  <= '0;
            state    <= mac;
          end
        end

        // Issue four weight reads, accumulate one cycle behind
        mac: begin
          if (col_cnt == (OCW + 1)'(NUM_OUT)) begin
            col_cnt <= '0;
            state   <= (row_left == '0) ? write_back : entry_fetch;
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end

        write_back: begin
          if (col_cnt == (OCW + 1)'(NUM_OUT - 1)) begin
            col_cnt <= '0;
            if (node_idx == NAW'(LAST_NODE)) begin
              gat_ready <= 1'b1;
              state     <= done;
            end else begin
              node_idx <= node_idx + 1'b1;
              state    <= row_fetch;
            end
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end

        done: begin
          if (!all_loaded) begin
            gat_ready <= 1'b0;
            state     <= idle;
          end
        end

        default: state <= idle;
      endcase
    end
  end

  // ============================================================
  // Datapath
  // ============================================================
  always_ff @(posedge clk) begin
    if (state == row_fetch && fetch_wait) begin
      acc <= '0;
    end
    if (state == entry_fetch && fetch_wait) begin
      ent_val <= h_dout.val;
      ent_col <= h_dout.col;
    end
    if (state == mac && col_cnt != '0) begin
      acc[mac_col] <= acc[mac_col] + FW'(prod);
    end
  end

  // Ready only between the last write and the next load
  a_ready_out_of_run : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state inside {row_fetch, entry_fetch, mac, write_back}) |-> !gat_ready
  ) else $error("gat_ready high during a run");

  a_h_ptr_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == entry_fetch) |-> (h_ptr < (`GAT_H_ADDR_W + 1)'(`GAT_H_NUM_SPARSE_DATA))
  ) else $error("h_data pointer %0d past memory depth", h_ptr);

endmodule

`default_nettype wire

/* rtl/gat_top.sv */
// GAT feature transform top
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module gat_top
  import gat_mem_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,

  // Register bank
  input  logic                         gat_layer,
  input  logic                         h_data_load_done,
  input  logic                         node_info_load_done,
  input  logic                         wgt_load_done,
  output logic                         gat_ready,

  // Host memory ports
  input  h_data_wr_t                   h_data_wr,
  input  node_info_wr_t                node_info_wr,
  input  wgt_wr_t                      wgt_wr,
  input  logic [`GAT_FEAT_ADDR_W-1:0]  feat_addrb,
  output logic [`GAT_FEAT_WIDTH-1:0]   feat_dout
);

  logic [`GAT_H_ADDR_W-1:0]    h_addrb;
  logic [`GAT_NODE_ADDR_W-1:0] node_info_addrb;
  logic [`GAT_WGT_ADDR_W-1:0]  wgt_addrb;
  h_entry_t                    h_dout;
  node_info_t                  node_info_dout;
  logic [`GAT_DATA_WIDTH-1:0]  wgt_dout;
  feat_wr_t                    feat_wr;

  gat_memory_controller u_memory_controller (
    .clk             (clk),
    .h_data_wr       (h_data_wr),
    .node_info_wr    (node_info_wr),
    .wgt_wr          (wgt_wr),
    .h_addrb         (h_addrb),
    .h_dout          (h_dout),
    .node_info_addrb (node_info_addrb),
    .node_info_dout  (node_info_dout),
    .wgt_addrb       (wgt_addrb),
    .wgt_dout        (wgt_dout),
    .feat_wr         (feat_wr),
    .feat_addrb      (feat_addrb),
    .feat_dout       (feat_dout)
  );

  gat_transform u_transform (
    .clk                 (clk),
    .rst_n               (rst_n),
    .h_data_load_done    (h_data_load_done),
    .node_info_load_done (node_info_load_done),
    .wgt_load_done       (wgt_load_done),
    .gat_layer           (gat_layer),
    .node_info_addrb     (node_info_addrb),
    .h_addrb             (h_addrb),
    .wgt_addrb           (wgt_addrb),
    .node_info_dout      (node_info_dout),
    .h_dout              (h_dout),
    .wgt_dout            (wgt_dout),
    .feat_wr             (feat_wr),
    .gat_ready           (gat_ready)
  );

endmodule

`default_nettype wire

/* test/tb_gat_top.sv */
// GAT front end testbench
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module tb_gat_top
  import gat_mem_pkg::*;
();

  localparam int NODES       = `GAT_TOTAL_NODES;
  localparam int FIN         = `GAT_NUM_FEATURE_IN;
  localparam int FOUT        = `GAT_NUM_FEATURE_OUT;
  localparam int WDEPTH      = `GAT_WGT_DEPTH;
  localparam int FDEPTH      = `GAT_FEAT_DEPTH;
  localparam int HDEPTH      = `GAT_H_NUM_SPARSE_DATA;
  localparam int EMPTY_NODE  = 3;
  localparam int RUN_TIMEOUT = 2000;
  localparam int DROP_WAIT   = 4;

  logic                         clk;
  logic                         rst_n;
  logic                         gat_layer;
  logic                         h_data_load_done;
  logic                         node_info_load_done;
  logic                         wgt_load_done;
  logic                         gat_ready;
  h_data_wr_t                   h_data_wr;
  node_info_wr_t                node_info_wr;
  wgt_wr_t                      wgt_wr;
  logic [`GAT_FEAT_ADDR_W-1:0]  feat_addrb;
  logic [`GAT_FEAT_WIDTH-1:0]   feat_dout;

  // Host copy of the data set
  logic [31:0]                  rng;
  int                           row_len [NODES];
  logic [7:0]                   h_val [HDEPTH];
  logic [`GAT_COL_IDX_W-1:0]    h_col [HDEPTH];
  logic [7:0]                   wgt [WDEPTH];
  int                           nnz_total;

  logic [31:0]                  exp_feat [FDEPTH];
  logic [31:0]                  prev_exp [FDEPTH];
  logic [31:0]                  rd_last [FDEPTH];
  logic [31:0]                  rd_layer0 [FDEPTH];
  logic [31:0]                  rd_layer1 [FDEPTH];

  int                           error_count;
  int                           check_count;
  int                           tests_run;
  int                           tests_failed;
  int                           test_err_start;
  logic                         timed_out;

  gat_top dut0 (
    .clk                 (clk),
    .rst_n               (rst_n),
    .gat_layer           (gat_layer),
    .h_data_load_done    (h_data_load_done),
    .node_info_load_done (node_info_load_done),
    .wgt_load_done       (wgt_load_done),
    .gat_ready           (gat_ready),
    .h_data_wr           (h_data_wr),
    .node_info_wr        (node_info_wr),
    .wgt_wr              (wgt_wr),
    .feat_addrb          (feat_addrb),
    .feat_dout           (feat_dout)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Any missing load drops ready by the next edge and keeps it low
  a_ready_needs_loads : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(h_data_load_done && node_info_load_done && wgt_load_done) |=> !gat_ready
  ) else begin
    $display("gat_ready still high one cycle after a load-done level was low");
    error_count++;
  end

  // ============================================================
  // Data set and reference model
  // ============================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic build_dataset();
    int need;
    int ptr;
    ptr = 0;
    for (int n = 0; n < NODES; n++) begin
      rng = xorshift32(rng);
      need = (n == EMPTY_NODE) ? 0 : int'(rng % 6);
      row_len[n] = need;
      // Selection sampling keeps the columns distinct and sorted
      for (int c = 0; c < FIN; c++) begin
        rng = xorshift32(rng);
        if (need > 0 && int'(rng % (FIN - c)) < need) begin
          rng = xorshift32(rng);
          h_col[ptr] = `GAT_COL_IDX_W'(c);
          h_val[ptr] = (rng[7:0] == 8'd0) ? 8'd1 : rng[7:0];
          ptr++;
          need--;
        end
      end
    end
    nnz_total = ptr;
    for (int a = 0; a < WDEPTH; a++) begin
      rng = xorshift32(rng);
      wgt[a] = rng[15:8];
    end
  endtask

  // Row n starts after the entries of rows 0 to n-1
  task automatic compute_golden(input int bank);
    int start;
    int sum;
    int waddr;
    start = 0;
    for (int n = 0; n < NODES; n++) begin
      for (int j = 0; j < FOUT; j++) begin
        sum = 0;
        for (int e = 0; e < row_len[n]; e++) begin
          waddr = bank * FIN * FOUT + int'(h_col[start + e]) * FOUT + j;
          sum += int'($signed(h_val[start + e])) * int'($signed(wgt[waddr]));
        end
        exp_feat[n * FOUT + j] = sum;
      end
      start += row_len[n];
    end
  endtask

  function automatic int count_changes();
    int n;
    n = 0;
    for (int a = 0; a < FDEPTH; a++) begin
      if (exp_feat[a] !== prev_exp[a]) n++;
    end
    return n;
  endfunction

  // ============================================================
  // Host port tasks
  // ============================================================
  task automatic load_node_info();
    node_info_wr_t wr;
    for (int n = 0; n < NODES; n++) begin
      wr.ena         = 1'b1;
      wr.wea         = 1'b1;
      wr.addr        = `GAT_NODE_ADDR_W'(n);
      wr.din.row_len = `GAT_ROW_LEN_W'(row_len[n]);
      @(posedge clk);
      node_info_wr <= wr;
    end
    @(posedge clk);
    node_info_wr <= '0;
  endtask

  task automatic load_weights();
    wgt_wr_t wr;
    for (int a = 0; a < WDEPTH; a++) begin
      wr.ena  = 1'b1;
      wr.wea  = 1'b1;
      wr.addr = `GAT_WGT_ADDR_W'(a);
      wr.din  = wgt[a];
      @(posedge clk);
      wgt_wr <= wr;
    end
    @(posedge clk);
    wgt_wr <= '0;
  endtask

  task automatic load_h_data();
    h_data_wr_t wr;
    for (int i = 0; i < nnz_total; i++) begin
      wr.ena     = 1'b1;
      wr.wea     = 1'b1;
      wr.addr    = `GAT_H_ADDR_W'(i);
      wr.din.val = h_val[i];
      wr.din.col = h_col[i];
      @(posedge clk);
      h_data_wr <= wr;
    end
    @(posedge clk);
    h_data_wr <= '0;
  endtask

  // Data is sampled one cycle after the address edge
  task automatic read_feature(input int addr, output logic [31:0] val);
    @(posedge clk);
    feat_addrb <= `GAT_FEAT_ADDR_W'(addr);
    @(posedge clk);
    @(negedge clk);
    val = feat_dout;
  endtask

  task automatic wait_for_ready(input logic level, input int max_cycles, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (gat_ready !== level && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (gat_ready !== level) begin
      $display("%s: gat_ready did not go %0s within %0d cycles",
               what, level ? "high" : "low", max_cycles);
      timed_out = 1'b1;
    end
  endtask

  // ============================================================
  // Checks and reporting
  // ============================================================
  task automatic check_value(input string test_name, input int addr,
                             input logic [31:0] exp, input logic [31:0] got);
    check_count++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: feature %0d expected %0d actual %0d",
               test_name, addr, $signed(exp), $signed(got));
      error_count++;
    end
  endtask

  task automatic check_ready_low(input string test_name);
    check_count++;
    assert (gat_ready === 1'b0) else begin
      $display("CHECK FAILED %s: gat_ready expected 0 actual %b", test_name, gat_ready);
      error_count++;
    end
  endtask

  task automatic check_changed(input string test_name);
    assert (count_changes() > 0) else begin
      $display("%s: new golden product equals the old one, stale data would go unseen",
               test_name);
      error_count++;
    end
  endtask

  task automatic read_and_check(input string test_name);
    logic [31:0] got;
    for (int a = 0; a < FDEPTH; a++) begin
      read_feature(a, got);
      check_value(test_name, a, exp_feat[a], got);
      rd_last[a] = got;
    end
  endtask

  task automatic finish_test(input string test_name);
    tests_run++;
    if (timed_out || error_count != test_err_start) tests_failed++;
    $display("test %-12s finished, %0d errors%0s", test_name,
             error_count - test_err_start, timed_out ? ", timed out" : "");
  endtask

  // ============================================================
  // Tests
  // ============================================================
  task automatic reset_keeps_idle();
    string name = "reset_idle";
    test_err_start = error_count;
    @(negedge clk);
    check_ready_low(name);
    load_node_info();
    load_weights();
    @(posedge clk);
    node_info_load_done <= 1'b1;
    wgt_load_done       <= 1'b1;
    // H still missing, no run may start
    repeat (20) begin
      @(negedge clk);
      check_ready_low(name);
    end
    finish_test(name);
  endtask

  task automatic layer0_product();
    string name = "layer0";
    test_err_start = error_count;
    load_h_data();
    @(posedge clk);
    gat_layer        <= 1'b0;
    h_data_load_done <= 1'b1;
    wait_for_ready(1'b1, RUN_TIMEOUT, name);
    if (!timed_out) begin
      compute_golden(0);
      read_and_check(name);
      rd_layer0 = rd_last;
    end
    finish_test(name);
  endtask

  task automatic layer1_rerun();
    string name = "layer1";
    test_err_start = error_count;
    prev_exp = exp_feat;
    @(posedge clk);
    wgt_load_done <= 1'b0;
    wait_for_ready(1'b0, DROP_WAIT, name);
    if (!timed_out) begin
      @(posedge clk);
      gat_layer     <= 1'b1;
      wgt_load_done <= 1'b1;
      wait_for_ready(1'b1, RUN_TIMEOUT, name);
    end
    if (!timed_out) begin
      compute_golden(1);
      check_changed(name);
      read_and_check(name);
      rd_layer1 = rd_last;
    end
    finish_test(name);
  endtask

  task automatic empty_rows();
    string name = "empty_rows";
    test_err_start = error_count;
    for (int n = 0; n < NODES; n++) begin
      if (row_len[n] == 0) begin
        for (int j = 0; j < FOUT; j++) begin
          check_value(name, n * FOUT + j, 32'd0, rd_layer0[n * FOUT + j]);
          check_value(name, n * FOUT + j, 32'd0, rd_layer1[n * FOUT + j]);
        end
      end
    end
    // Dropping the row length load clears ready as well
    @(posedge clk);
    node_info_load_done <= 1'b0;
    wait_for_ready(1'b0, DROP_WAIT, name);
    if (!timed_out) begin
      @(posedge clk);
      node_info_load_done <= 1'b1;
      wait_for_ready(1'b1, RUN_TIMEOUT, name);
    end
    finish_test(name);
  endtask

  task automatic reload_h();
    string name = "reload_h";
    test_err_start = error_count;
    prev_exp = exp_feat;
    @(posedge clk);
    h_data_load_done <= 1'b0;
    wait_for_ready(1'b0, DROP_WAIT, name);
    if (!timed_out) begin
      // Flipping bit 0 makes every value differ from the last load
      for (int i = 0; i < nnz_total; i++) begin
        rng = xorshift32(rng);
        h_val[i] = {rng[7:1], ~h_val[i][0]};
      end
      load_h_data();
      @(posedge clk);
      h_data_load_done <= 1'b1;
      wait_for_ready(1'b1, RUN_TIMEOUT, name);
    end
    if (!timed_out) begin
      compute_golden(1);
      check_changed(name);
      read_and_check(name);
    end
    finish_test(name);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    rst_n               = 1'b0;
    gat_layer           = 1'b0;
    h_data_load_done    = 1'b0;
    node_info_load_done = 1'b0;
    wgt_load_done       = 1'b0;
    h_data_wr           = '0;
    node_info_wr        = '0;
    wgt_wr              = '0;
    feat_addrb          = '0;
    rng                 = 32'hbae9;
    error_count         = 0;
    check_count         = 0;
    tests_run           = 0;
    tests_failed        = 0;
    test_err_start      = 0;
    timed_out           = 1'b0;

    build_dataset();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    reset_keeps_idle();
    if (!timed_out) layer0_product();
    if (!timed_out) layer1_rerun();
    if (!timed_out) empty_rows();
    if (!timed_out) reload_h();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (timed_out || error_count != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
rtl/gat_mem_pkg.sv
rtl/gat_core_pkg.sv
rtl/gat_bram.sv
rtl/gat_memory_controller.sv
rtl/gat_transform.sv
rtl/gat_top.sv
test/tb_gat_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GAT front end testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_gat_top \
  --Mdir "$BUILD_DIR" -o tb_gat_top -f all.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/tb_gat_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
